//--- logic/perf_pkg.sv
package perf_pkg;

  localparam int ADDR_W = 20;
  localparam int DATA_W = 16;
  localparam int ID_W   = 4;
  localparam int STRB_W = DATA_W / 8;

  // write address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic [7:0]        len;
    logic [2:0]        size;
    logic [1:0]        burst;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } axi_w_t;

  // beats must be at least 1, num_bursts of 0 gives an empty run
  typedef struct packed {
    logic [ADDR_W-1:0] base_addr;
    logic [7:0]        beats;
    logic [ADDR_W-1:0] stride;
    logic [15:0]       num_bursts;
  } wr_cfg_t;

  typedef enum logic [1:0] {
    STAT_BURSTS = 2'd0,
    STAT_BEATS  = 2'd1,
    STAT_STALLS = 2'd2,
    STAT_ERRORS = 2'd3
  } stat_id_e;

  typedef enum logic [2:0] {
    IDLE,
    RUN,
    RUN_WAIT,
    REPORT,
    REPORT_WAIT,
    DONE
  } seq_state_e;

endpackage

//--- logic/perf_sequencer.sv
`timescale 1ns/1ps

module perf_sequencer
  import perf_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic wr_busy,
  input  logic rpt_busy,
  output logic wr_start,
  output logic rpt_start,
  output logic done
);

  seq_state_e state;
  seq_state_e state_next;

  always_comb begin
    state_next = state;

    case (state)
      IDLE: begin
        if (start) begin
          state_next = RUN;
        end
      end

      RUN: begin
        state_next = RUN_WAIT;
      end

      // the writer raises busy in the cycle after wr_start, so this
      // state already sees it high on entry
      RUN_WAIT: begin
        if (!wr_busy) begin
          state_next = REPORT;
        end
      end

      REPORT: begin
        state_next = REPORT_WAIT;
      end

      REPORT_WAIT: begin
        if (!rpt_busy) begin
          state_next = DONE;
        end
      end

      DONE: begin
        if (start) begin
          state_next = RUN;
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // start pulses are one cycle long since RUN and REPORT last one cycle
  assign wr_start  = (state == RUN);
  assign rpt_start = (state == REPORT);
  assign done      = (state == DONE);

endmodule

//--- logic/burst_writer.sv
`timescale 1ns/1ps

module burst_writer
  import perf_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    wr_start,
  input  wr_cfg_t cfg,
  output axi_aw_t aw,
  output logic    awvalid,
  input  logic    awready,
  output axi_w_t  w,
  output logic    wvalid,
  input  logic    wready,
  input  logic    bvalid,
  output logic    bready,
  output logic    wr_busy
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_ADDR,
    PH_DATA,
    PH_RESP
  } phase_e;

  phase_e            phase;
  wr_cfg_t           cfg_q;
  logic [15:0]       burst_cnt;
  logic [7:0]        beat_cnt;
  logic [ADDR_W-1:0] addr;
  logic              last_beat;
  logic              last_burst;

  assign last_beat  = (beat_cnt == cfg_q.beats - 8'd1);
  assign last_burst = (burst_cnt == cfg_q.num_bursts - 16'd1);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase     <= PH_IDLE;
      burst_cnt <= '0;
      beat_cnt  <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (wr_start && cfg.num_bursts != 16'd0) begin
            cfg_q     <= cfg;
            addr      <= cfg.base_addr;
            burst_cnt <= '0;
            beat_cnt  <= '0;
            phase     <= PH_ADDR;
          end
        end

        PH_ADDR: begin
          if (awready) begin
            beat_cnt <= '0;
            phase    <= PH_DATA;
          end
        end

        PH_DATA: begin
          if (wready) begin
            if (last_beat) begin
              phase <= PH_RESP;
            end else begin
              beat_cnt <= beat_cnt + 8'd1;
            end
          end
        end

        PH_RESP: begin
          if (bvalid) begin
            if (last_burst) begin
              phase <= PH_IDLE;
            end else begin
              burst_cnt <= burst_cnt + 16'd1;
              addr      <= addr + cfg_q.stride;
              phase     <= PH_ADDR;
            end
          end
        end

        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  // payloads come only from registers, so they hold while a channel stalls
  assign aw.addr  = addr;
  assign aw.id    = burst_cnt[ID_W-1:0];
  assign aw.len   = cfg_q.beats - 8'd1;
  assign aw.size  = 3'($clog2(STRB_W));
  assign aw.burst = 2'b01;

  assign w.data = {burst_cnt[7:0], beat_cnt};
  assign w.strb = '1;
  assign w.last = last_beat && wvalid;

  assign awvalid = (phase == PH_ADDR);
  assign wvalid  = (phase == PH_DATA);
  assign bready  = (phase == PH_RESP);
  assign wr_busy = (phase != PH_IDLE);

endmodule

//--- logic/write_stats.sv
`timescale 1ns/1ps

module write_stats
  import perf_pkg::*;
#(
  parameter int STAT_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              clear,
  input  logic              awvalid,
  input  logic              awready,
  input  logic              wvalid,
  input  logic              wready,
  input  logic              bvalid,
  input  logic              bready,
  input  logic [1:0]        bresp,
  input  stat_id_e          stat_sel,
  output logic [STAT_W-1:0] stat_val
);

  logic [STAT_W-1:0] cnt [4];
  logic [3:0]        inc;

  // one event bit per counter, indexed by stat id
  always_comb begin
    inc[STAT_BURSTS] = awvalid && awready;
    inc[STAT_BEATS]  = wvalid && wready;
    inc[STAT_STALLS] = wvalid && !wready;
    inc[STAT_ERRORS] = bvalid && bready && (bresp != 2'b00);
  end

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      for (int i = 0; i < 4; i++) begin
        cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        // counters stick at all ones instead of wrapping
        if (inc[i] && cnt[i] != '1) begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign stat_val = cnt[stat_sel];

endmodule

//--- logic/stat_printer.sv
`timescale 1ns/1ps

module stat_printer
  import perf_pkg::*;
#(
  parameter int STAT_W = 32
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              rpt_start,
  input  logic [STAT_W-1:0] stat_val,
  input  logic              tx_busy,
  output stat_id_e          stat_sel,
  output logic              tx_en,
  output logic [7:0]        tx_data,
  output logic              rpt_busy
);

  // a line is "NN: 0x" then the value digits then CR LF
  localparam int NIBBLES  = STAT_W / 4;
  localparam int LINE_LEN = NIBBLES + 8;
  localparam int IDX_W    = $clog2(LINE_LEN);

  typedef enum logic [1:0] {
    P_IDLE,
    P_SEND,
    P_DRAIN
  } prn_state_e;

  prn_state_e       state;
  logic [IDX_W-1:0] char_idx;
  logic [7:0]       cur_char;
  logic             can_send;

  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    return (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
  endfunction

  always_comb begin
    case (int'(char_idx))
      0: cur_char = hex_char(4'h0);
      1: cur_char = hex_char({2'b00, stat_sel});
      2: cur_char = ":";
      3: cur_char = " ";
      4: cur_char = "0";
      5: cur_char = "x";
      LINE_LEN - 2: cur_char = 8'h0d;
      LINE_LEN - 1: cur_char = 8'h0a;
      default: cur_char = hex_char(4'(stat_val >> (4 * (NIBBLES + 5 - int'(char_idx)))));
    endcase
  end

  // tx_busy only rises the cycle after tx_en, so skip that cycle too
  assign can_send = !tx_busy && !tx_en;

  always_ff @(posedge clk) begin
    tx_en <= 1'b0;
    if (!rst_n) begin
      state    <= P_IDLE;
      char_idx <= '0;
      stat_sel <= STAT_BURSTS;
    end else begin
      case (state)
        P_IDLE: begin
          if (rpt_start) begin
            char_idx <= '0;
            stat_sel <= STAT_BURSTS;
            state    <= P_SEND;
          end
        end

        P_SEND: begin
          if (can_send) begin
            tx_en   <= 1'b1;
            tx_data <= cur_char;
            if (int'(char_idx) == LINE_LEN - 1) begin
              char_idx <= '0;
              if (stat_sel == STAT_ERRORS) begin
                state <= P_DRAIN;
              end else begin
                stat_sel <= stat_id_e'(stat_sel + 2'd1);
              end
            end else begin
              char_idx <= char_idx + 1'b1;
            end
          end
        end

        P_DRAIN: begin
          if (can_send) begin
            state <= P_IDLE;
          end
        end

        default: begin
          state <= P_IDLE;
        end
      endcase
    end
  end

  assign rpt_busy = (state != P_IDLE);

endmodule

//--- logic/uart_tx.sv
`timescale 1ns/1ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 868
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_en,
  input  logic [7:0] tx_data,
  output logic       tx_busy,
  output logic       utx_pin
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic [8:0]       shift;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tx_busy  <= 1'b0;
      utx_pin  <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (!tx_busy) begin
      if (tx_en) begin
        // start bit goes out now, stop bit waits at the top of the shifter
        shift    <= {1'b1, tx_data};
        utx_pin  <= 1'b0;
        tx_busy  <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
    end else if (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      baud_cnt <= '0;
      if (bit_idx == 4'd9) begin
        tx_busy <= 1'b0;
      end else begin
        utx_pin <= shift[0];
        shift   <= {1'b1, shift[8:1]};
        bit_idx <= bit_idx + 4'd1;
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

//--- logic/axi_perf_top.sv
`timescale 1ns/1ps

module axi_perf_top
  import perf_pkg::*;
#(
  parameter int CLKS_PER_BIT = 868,
  parameter int STAT_W       = 32
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  wr_cfg_t    cfg,
  output axi_aw_t    aw,
  output logic       awvalid,
  input  logic       awready,
  output axi_w_t     w,
  output logic       wvalid,
  input  logic       wready,
  input  logic       bvalid,
  input  logic [1:0] bresp,
  output logic       bready,
  output logic       utx_pin,
  output logic       done
);

  logic              wr_start;
  logic              wr_busy;
  logic              rpt_start;
  logic              rpt_busy;
  stat_id_e          stat_sel;
  logic [STAT_W-1:0] stat_val;
  logic              tx_en;
  logic [7:0]        tx_data;
  logic              tx_busy;

  perf_sequencer i_sequencer (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .wr_busy  (wr_busy),
    .rpt_busy (rpt_busy),
    .wr_start (wr_start),
    .rpt_start(rpt_start),
    .done     (done)
  );

  burst_writer i_writer (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_start(wr_start),
    .cfg     (cfg),
    .aw      (aw),
    .awvalid (awvalid),
    .awready (awready),
    .w       (w),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .wr_busy (wr_busy)
  );

  // counters restart with every run
  write_stats #(
    .STAT_W(STAT_W)
  ) i_stats (
    .clk     (clk),
    .rst_n   (rst_n),
    .clear   (wr_start),
    .awvalid (awvalid),
    .awready (awready),
    .wvalid  (wvalid),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .stat_sel(stat_sel),
    .stat_val(stat_val)
  );

  stat_printer #(
    .STAT_W(STAT_W)
  ) i_printer (
    .clk      (clk),
    .rst_n    (rst_n),
    .rpt_start(rpt_start),
    .stat_val (stat_val),
    .tx_busy  (tx_busy),
    .stat_sel (stat_sel),
    .tx_en    (tx_en),
    .tx_data  (tx_data),
    .rpt_busy (rpt_busy)
  );

  uart_tx #(
    .CLKS_PER_BIT(CLKS_PER_BIT)
  ) i_uart (
    .clk    (clk),
    .rst_n  (rst_n),
    .tx_en  (tx_en),
    .tx_data(tx_data),
    .tx_busy(tx_busy),
    .utx_pin(utx_pin)
  );

endmodule

//--- testbench/axi_perf_checker.sv
`timescale 1ns/1ps

module axi_perf_checker
  import perf_pkg::*;
(
  input logic    clk,
  input logic    rst_n,
  input axi_aw_t aw,
  input logic    awvalid,
  input logic    awready,
  input axi_w_t  w,
  input logic    wvalid,
  input logic    wready,
  input logic    done
);

  int unsigned aw_fails   = 0;
  int unsigned w_fails    = 0;
  int unsigned last_fails = 0;
  int unsigned idle_fails = 0;
  int unsigned fail_count;

  always_comb begin
    fail_count = aw_fails + w_fails + last_fails + idle_fails;
  end

  aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(aw))
    else begin
      aw_fails++;
      $error("aw payload or awvalid changed while waiting for awready");
    end

  w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(w))
    else begin
      w_fails++;
      $error("w payload or wvalid changed while waiting for wready");
    end

  // the last flag only belongs to a beat that is on offer
  wlast_with_wvalid: assert property (@(posedge clk) disable iff (!rst_n)
    w.last |-> wvalid)
    else begin
      last_fails++;
      $error("wlast was high without wvalid");
    end

  done_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !(done && awvalid))
    else begin
      idle_fails++;
      $error("done and awvalid were high together");
    end

endmodule

bind axi_perf_top axi_perf_checker i_checker (
  .clk    (clk),
  .rst_n  (rst_n),
  .aw     (aw),
  .awvalid(awvalid),
  .awready(awready),
  .w      (w),
  .wvalid (wvalid),
  .wready (wready),
  .done   (done)
);

//--- testbench/tb_axi_perf.sv
`timescale 1ns/1ps

module tb_axi_perf
  import perf_pkg::*;
();

  localparam int          CLKS_PER_BIT = 8;
  localparam int          STAT_W       = 32;
  localparam int          LINE_BYTES   = STAT_W / 4 + 8;
  localparam int          REPORT_BYTES = 4 * LINE_BYTES;
  localparam int          WAIT_LIMIT   = 20000;
  localparam logic [31:0] SEED         = 32'h51a01d72;

  logic       clk;
  logic       rst_n;
  logic       start;
  wr_cfg_t    cfg;
  axi_aw_t    aw;
  logic       awvalid;
  logic       awready = 1'b0;
  axi_w_t     w;
  logic       wvalid;
  logic       wready  = 1'b0;
  logic       bvalid  = 1'b0;
  logic [1:0] bresp   = 2'b00;
  logic       bready;
  logic       utx_pin;
  logic       done;

  logic        random_ready;
  logic [15:0] err_mask;
  logic [31:0] rng_state = SEED;
  logic        b_pending = 1'b0;
  int          b_count   = 0;
  int          stall_cnt = 0;
  axi_aw_t     aw_log[$];
  axi_w_t      w_log[$];
  int          aw_base;
  int          w_base;
  int          stall_base;
  int          b_base;
  logic [7:0]  report_bytes [REPORT_BYTES];
  int          mismatch_count = 0;
  int          other_count    = 0;
  logic        timed_out      = 1'b0;

  axi_perf_top #(
    .CLKS_PER_BIT(CLKS_PER_BIT),
    .STAT_W      (STAT_W)
  ) i_dut (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .cfg    (cfg),
    .aw     (aw),
    .awvalid(awvalid),
    .awready(awready),
    .w      (w),
    .wvalid (wvalid),
    .wready (wready),
    .bvalid (bvalid),
    .bresp  (bresp),
    .bready (bready),
    .utx_pin(utx_pin),
    .done   (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // slave side of the AXI port, driven on the falling edge
  always @(negedge clk) begin
    rng_state = next_random(rng_state);
    if (random_ready) begin
      awready <= rng_state[3];
      wready  <= rng_state[12] | rng_state[21];
    end else begin
      awready <= 1'b1;
      wready  <= 1'b1;
    end
    bvalid <= b_pending;
    if (b_pending && err_mask[4'(b_count - b_base)]) begin
      bresp <= 2'b10;
    end else begin
      bresp <= 2'b00;
    end
  end

  // transfer log and stall count, taken at the ports
  always @(posedge clk) begin
    if (awvalid && awready) begin
      aw_log.push_back(aw);
    end
    if (wvalid && wready) begin
      w_log.push_back(w);
      if (w.last) begin
        b_pending <= 1'b1;
      end
    end
    if (wvalid && !wready) begin
      stall_cnt <= stall_cnt + 1;
    end
    if (bvalid && bready) begin
      b_pending <= 1'b0;
      b_count   <= b_count + 1;
    end
  end

  task automatic end_test();
    int assert_fails;
    assert_fails = int'(i_dut.i_checker.fail_count);
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatch_count, other_count, assert_fails);
    if (mismatch_count == 0 && other_count == 0 && assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // later waits return at once, so the run goes straight to its closing line
  task automatic report_timeout(input string what);
    other_count++;
    timed_out = 1'b1;
    $display("Timeout at %0t: %s", $time, what);
  endtask

  task automatic check_field(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    end
  endtask

  task automatic start_run(input logic [ADDR_W-1:0] base, input logic [7:0] beats,
                           input logic [ADDR_W-1:0] stride, input logic [15:0] bursts);
    @(negedge clk);
    cfg.base_addr  = base;
    cfg.beats      = beats;
    cfg.stride     = stride;
    cfg.num_bursts = bursts;
    aw_base    = aw_log.size();
    w_base     = w_log.size();
    stall_base = stall_cnt;
    b_base     = b_count;
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done !== 1'b1 && n < WAIT_LIMIT && !timed_out) begin
      @(negedge clk);
      n++;
    end
    if (done !== 1'b1 && !timed_out) begin
      report_timeout("done never rose");
    end
  endtask

  // samples each bit at its middle, the start bit is found on a falling edge
  task automatic receive_byte(output logic [7:0] data);
    int n;
    n = 0;
    data = 8'h00;
    if (timed_out) begin
      return;
    end
    while (utx_pin !== 1'b0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (utx_pin !== 1'b0) begin
      report_timeout("no UART start bit");
      return;
    end
    repeat (CLKS_PER_BIT / 2) @(negedge clk);
    if (utx_pin !== 1'b0) begin
      other_count++;
      $display("UART start bit too short at %0t", $time);
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data[i] = utx_pin;
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    if (utx_pin !== 1'b1) begin
      other_count++;
      $display("UART stop bit missing at %0t", $time);
    end
  endtask

  task automatic receive_report();
    for (int i = 0; i < REPORT_BYTES; i++) begin
      receive_byte(report_bytes[i]);
    end
  endtask

  task automatic compare_report(input logic [31:0] bursts, input logic [31:0] beats,
                                input logic [31:0] stalls, input logic [31:0] errors);
    logic [31:0] val;
    string       digits;
    logic [7:0]  exp_char;
    if (timed_out) begin
      return;
    end
    for (int id = 0; id < 4; id++) begin
      case (id)
        0: val = bursts;
        1: val = beats;
        2: val = stalls;
        default: val = errors;
      endcase
      digits = $sformatf("%02h%08h", id[7:0], val);
      digits = digits.toupper();
      for (int c = 0; c < LINE_BYTES; c++) begin
        if (c < 2) begin
          exp_char = digits[c];
        end else if (c == 2) begin
          exp_char = ":";
        end else if (c == 3) begin
          exp_char = " ";
        end else if (c == 4) begin
          exp_char = "0";
        end else if (c == 5) begin
          exp_char = "x";
        end else if (c == LINE_BYTES - 2) begin
          exp_char = 8'h0d;
        end else if (c == LINE_BYTES - 1) begin
          exp_char = 8'h0a;
        end else begin
          exp_char = digits[c - 4];
        end
        if (report_bytes[id * LINE_BYTES + c] !== exp_char) begin
          mismatch_count++;
          $display("Mismatch at %0t: utx_pin line %0d char %0d expected %02h got %02h",
                   $time, id, c, exp_char, report_bytes[id * LINE_BYTES + c]);
        end
      end
    end
  endtask

  task automatic check_transfers(input logic [ADDR_W-1:0] base, input int beats,
                                 input logic [ADDR_W-1:0] stride, input int bursts);
    axi_aw_t           a;
    axi_w_t            d;
    logic [ADDR_W-1:0] exp_addr;
    int                k;
    int                j;
    if (timed_out) begin
      return;
    end
    check_field("AW transfer count", bursts, aw_log.size() - aw_base);
    check_field("W transfer count", bursts * beats, w_log.size() - w_base);
    exp_addr = base;
    for (int i = 0; i < bursts && aw_base + i < aw_log.size(); i++) begin
      a = aw_log[aw_base + i];
      check_field($sformatf("aw[%0d].addr", i), exp_addr, a.addr);
      check_field($sformatf("aw[%0d].id", i), i % 16, a.id);
      check_field($sformatf("aw[%0d].len", i), beats - 1, a.len);
      check_field($sformatf("aw[%0d].size", i), 1, a.size);
      check_field($sformatf("aw[%0d].burst", i), 1, a.burst);
      exp_addr = exp_addr + stride;
    end
    for (int i = 0; i < bursts * beats && w_base + i < w_log.size(); i++) begin
      d = w_log[w_base + i];
      k = i / beats;
      j = i % beats;
      check_field($sformatf("w[%0d].data", i), {k[7:0], j[7:0]}, d.data);
      check_field($sformatf("w[%0d].strb", i), 2'b11, d.strb);
      check_field($sformatf("w[%0d].last", i), j == beats - 1, d.last);
    end
  endtask

  task automatic test_reset_idle();
    logic seen_low;
    seen_low = 1'b0;
    check_field("done", 0, done);
    check_field("awvalid", 0, awvalid);
    check_field("wvalid", 0, wvalid);
    check_field("bready", 0, bready);
    check_field("utx_pin", 1, utx_pin);
    repeat (200) begin
      @(negedge clk);
      seen_low = seen_low | (utx_pin !== 1'b1);
    end
    if (seen_low) begin
      other_count++;
      $display("UART line left idle without a start pulse");
    end
  endtask

  task automatic test_single_run();
    start_run(20'h00100, 8'd4, 20'h00040, 16'd2);
    receive_report();
    if (done !== 1'b0) begin
      other_count++;
      $display("done rose before the report had finished at %0t", $time);
    end
    wait_done();
    check_transfers(20'h00100, 4, 20'h00040, 2);
    compare_report(2, 8, 0, 0);
  endtask

  task automatic test_backpressure();
    random_ready = 1'b1;
    start_run(20'h10000, 8'd7, 20'h00020, 16'd5);
    receive_report();
    wait_done();
    random_ready = 1'b0;
    check_transfers(20'h10000, 7, 20'h00020, 5);
    compare_report(5, 35, stall_cnt - stall_base, 0);
  endtask

  task automatic test_error_responses();
    err_mask = 16'b1010;
    start_run(20'h20000, 8'd3, 20'h00100, 16'd4);
    receive_report();
    wait_done();
    err_mask = '0;
    check_transfers(20'h20000, 3, 20'h00100, 4);
    compare_report(4, 12, 0, 2);
  endtask

  // starts from done, wraps the address and sends a start in the middle of the run
  task automatic test_restart();
    start_run(20'hfffc0, 8'd2, 20'h00040, 16'd3);
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    receive_report();
    wait_done();
    check_transfers(20'hfffc0, 2, 20'h00040, 3);
    compare_report(3, 6, 0, 0);
  endtask

  initial begin
    rst_n        = 1'b0;
    start        = 1'b0;
    cfg          = '0;
    random_ready = 1'b0;
    err_mask     = '0;
    aw_base      = 0;
    w_base       = 0;
    stall_base   = 0;
    b_base       = 0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    test_reset_idle();
    test_single_run();
    test_backpressure();
    test_error_responses();
    test_restart();
    end_test();
  end

endmodule

//--- all.f
logic/perf_pkg.sv
logic/perf_sequencer.sv
logic/burst_writer.sv
logic/write_stats.sv
logic/stat_printer.sv
logic/uart_tx.sv
logic/axi_perf_top.sv
testbench/axi_perf_checker.sv
testbench/tb_axi_perf.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_perf
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
